// File: Bender.yml
package:
  name: pet_bus

sources:
  - rtl/pet_bus_pkg.sv
  - rtl/slot_timer.sv
  - rtl/cpu_addr_decode.sv
  - rtl/host_ram_bridge.sv
  - rtl/ram_bus_driver.sv
  - rtl/pet_bus_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_pet_bus.sv

// File: dv/tb_pet_bus_checks.svh
////////////////////////////////////////
// Compare tasks and error counters for the
// PET bus testbench, included in its top module
////////////////////////////////////////

`ifndef TB_PET_BUS_CHECKS_SVH
`define TB_PET_BUS_CHECKS_SVH

int decode_errors = 0;
int addr_errors   = 0;
int data_errors   = 0;

// Single strobe or chip select
task automatic check_decode(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        decode_errors++;
        $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
    end
endtask

task automatic check_addr(input string name,
                          input logic [pet_bus_pkg::ADDR_WIDTH-1:0] exp,
                          input logic [pet_bus_pkg::ADDR_WIDTH-1:0] got);
    if (got !== exp) begin
        addr_errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
endtask

task automatic check_data(input string name,
                          input logic [pet_bus_pkg::DATA_WIDTH-1:0] exp,
                          input logic [pet_bus_pkg::DATA_WIDTH-1:0] got);
    if (got !== exp) begin
        data_errors++;
        $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
endtask

`endif

// File: dv/tb_pet_bus.sv
////////////////////////////////////////
// Testbench for the PET bus core. Runs one table
// entry per frame, then two back-to-back host reads
////////////////////////////////////////

`timescale 1ns/10ps

module tb_pet_bus;

    `include "tb_pet_bus_checks.svh"

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_ENTRIES = 14;
    localparam logic [1:0] HOST_NONE  = 2'd0;
    localparam logic [1:0] HOST_WRITE = 2'd1;
    localparam logic [1:0] HOST_READ  = 2'd2;

    typedef struct packed {
        logic [15:0] cpu_addr;
        logic        cpu_we;
        logic [1:0]  vram_mask;
        logic        col_80;
        logic [1:0]  host_op;
        logic [15:0] host_addr;
    } stim_t;

    logic sys_clock_i, sys_reset_ni, cpu_we_i, col_80_mode_i, host_cyc_i, host_stb_i;
    logic [15:0] cpu_addr_i, ram_addr_o;
    logic [7:0]  cpu_data_i, cpu_data_o, host_data_o;
    logic [1:0]  vram_mask_i;
    logic cpu_data_oe_o, cpu_be_o, cpu_clock_o, ram_oe_o, ram_we_o;
    logic io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o, host_stall_o, host_ack_o;
    pet_bus_pkg::host_req_t host_req_i;
    stim_t stim [NUM_ENTRIES];

    pet_bus_top uut (.*);

    initial begin
        sys_clock_i = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clock_i = ~sys_clock_i;
    end

    initial begin
        #(NUM_ENTRIES * pet_bus_pkg::FRAME_PHASES * CLK_PERIOD * 4);
        $display("Timeout: the DUT did not finish the test sequence in time");
        $display("Test FAILED");
        $finish;
    end

    // Returns 2 ns after the edge that starts phase 0
    task automatic align_frame();
        logic prev;
        prev = cpu_be_o;
        forever begin
            @(posedge sys_clock_i);
            #2;
            if (cpu_be_o && !prev) break;
            prev = cpu_be_o;
        end
    endtask

    task automatic run_entry(input stim_t e, input bit keep_stb, input logic [15:0] next_addr);
        logic [7:0]  wdata;
        logic [7:0]  rdata;
        logic [15:0] exp_cpu_addr;
        logic        io, rd_ram, wr_ram, is_wr, is_rd, in_cpu;
        wdata  = 8'($urandom);
        rdata  = 8'($urandom);
        is_wr  = (e.host_op == HOST_WRITE);
        is_rd  = (e.host_op == HOST_READ);
        io     = (e.cpu_addr[15:8] == 8'hE8);
        rd_ram = !e.cpu_we && !io;
        wr_ram = e.cpu_we && !io && (e.cpu_addr < 16'h9000);
        exp_cpu_addr = e.cpu_addr;
        if (e.cpu_addr[15:12] == 4'h8) begin     // Video RAM wraps
            exp_cpu_addr[10] = e.cpu_addr[10] && (e.vram_mask[0] || e.col_80);
            exp_cpu_addr[11] = e.cpu_addr[11] && e.vram_mask[1];
        end
        cpu_addr_i    = e.cpu_addr;
        cpu_we_i      = e.cpu_we;
        vram_mask_i   = e.vram_mask;
        col_80_mode_i = e.col_80;
        host_cyc_i    = is_wr || is_rd;
        host_stb_i    = is_wr || is_rd;
        host_req_i    = '{addr: e.host_addr, data: wdata, we: is_wr};
        @(negedge sys_clock_i);
        check_decode("host_stall_o", 1'b0, host_stall_o);
        check_decode("cpu_be_o", 1'b1, cpu_be_o);
        check_decode("cpu_clock_o", 1'b0, cpu_clock_o);
        for (int p = 1; p < pet_bus_pkg::FRAME_PHASES; p++) begin
            @(posedge sys_clock_i);
            #2;
            if (p == 1 && keep_stb) begin
                host_req_i = '{addr: next_addr, data: 8'h00, we: 1'b0};   // Held while stalled
            end else if (p == 1) begin
                host_cyc_i = 1'b0;
                host_stb_i = 1'b0;
            end
            if (p == 7) cpu_data_i = rdata;
            @(negedge sys_clock_i);
            in_cpu = (p <= 3);
            check_decode("cpu_be_o", in_cpu, cpu_be_o);
            check_decode("cpu_clock_o", p == 2 || p == 3, cpu_clock_o);
            check_decode("ram_oe_o", (in_cpu && rd_ram) || (is_rd && p >= 5), ram_oe_o);
            check_decode("ram_we_o", (p == 3 && wr_ram) || (is_wr && p == 6), ram_we_o);
            check_decode("io_oe_o", in_cpu && io, io_oe_o);
            check_decode("pia1_cs_o", in_cpu && io && e.cpu_addr[7:4] == 4'h1, pia1_cs_o);
            check_decode("pia2_cs_o", in_cpu && io && e.cpu_addr[7:4] == 4'h2, pia2_cs_o);
            check_decode("via_cs_o", in_cpu && io && e.cpu_addr[7:4] == 4'h4, via_cs_o);
            check_decode("cpu_data_oe_o", is_wr && p >= 4, cpu_data_oe_o);
            check_decode("host_ack_o", (is_wr || is_rd) && p == 7, host_ack_o);
            check_decode("host_stall_o", is_wr || is_rd, host_stall_o);
            if (in_cpu) check_addr("ram_addr_o", exp_cpu_addr, ram_addr_o);
            else if (is_wr || is_rd) check_addr("ram_addr_o", e.host_addr, ram_addr_o);
            if (is_wr && p == 6) check_data("cpu_data_o", wdata, cpu_data_o);
            if (is_rd && p == 7) check_data("host_data_o", rdata, host_data_o);
        end
    endtask

    initial begin
        void'($urandom(32'ha988_a574));
        stim[0]  = '{16'h1234, 1'b0, 2'b11, 1'b0, HOST_NONE,  16'h0000};
        stim[1]  = '{16'h1234, 1'b1, 2'b11, 1'b0, HOST_WRITE, 16'h0100};
        stim[2]  = '{16'h8C55, 1'b0, 2'b00, 1'b0, HOST_READ,  16'h0200};
        stim[3]  = '{16'h8C55, 1'b0, 2'b01, 1'b0, HOST_NONE,  16'h0000};
        stim[4]  = '{16'h8C55, 1'b1, 2'b00, 1'b1, HOST_NONE,  16'h0000};
        stim[5]  = '{16'h8C55, 1'b0, 2'b10, 1'b0, HOST_WRITE, 16'h8C55};
        stim[6]  = '{16'h9000, 1'b1, 2'b11, 1'b0, HOST_WRITE, 16'h7FFF};
        stim[7]  = '{16'hC000, 1'b0, 2'b11, 1'b0, HOST_NONE,  16'h0000};
        stim[8]  = '{16'hE810, 1'b0, 2'b11, 1'b0, HOST_READ,  16'h3A5C};
        stim[9]  = '{16'hE820, 1'b1, 2'b11, 1'b0, HOST_READ,  16'hFFFF};
        stim[10] = '{16'hE840, 1'b0, 2'b11, 1'b0, HOST_NONE,  16'h0000};
        stim[11] = '{16'hE8F0, 1'b0, 2'b11, 1'b0, HOST_NONE,  16'h0000};
        stim[12] = '{16'hFFFF, 1'b1, 2'b11, 1'b0, HOST_WRITE, 16'h0001};
        stim[13] = '{16'h0C00, 1'b0, 2'b00, 1'b0, HOST_NONE,  16'h0000};
        sys_reset_ni  = 1'b0;
        cpu_addr_i    = '0;
        cpu_we_i      = 1'b0;
        cpu_data_i    = '0;
        vram_mask_i   = 2'b11;
        col_80_mode_i = 1'b0;
        host_cyc_i    = 1'b0;
        host_stb_i    = 1'b0;
        host_req_i    = '0;
        repeat (4) @(posedge sys_clock_i);
        #2 sys_reset_ni = 1'b1;
        @(negedge sys_clock_i);
        check_decode("ram_oe_o", 1'b0, ram_oe_o);      // Idle after reset
        check_decode("ram_we_o", 1'b0, ram_we_o);
        check_decode("cpu_data_oe_o", 1'b0, cpu_data_oe_o);
        check_decode("io_oe_o", 1'b0, io_oe_o | pia1_cs_o | pia2_cs_o | via_cs_o);
        check_decode("host_ack_o", 1'b0, host_ack_o);
        check_decode("host_stall_o", 1'b0, host_stall_o);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            align_frame();
            run_entry(stim[i], 1'b0, 16'h0000);
        end
        // Second read queued behind the first
        align_frame();
        run_entry('{16'h0000, 1'b0, 2'b11, 1'b0, HOST_READ, 16'h4321}, 1'b1, 16'h5678);
        align_frame();
        run_entry('{16'h0000, 1'b0, 2'b11, 1'b0, HOST_READ, 16'h5678}, 1'b0, 16'h0000);
        $display("Errors: decode %0d, addr %0d, data %0d", decode_errors, addr_errors,
                 data_errors);
        if (decode_errors + addr_errors + data_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/cpu_addr_decode.sv
////////////////////////////////////////
// CPU address decode stage. Captures the CPU
// request at the end of phase 0 and holds it
// with its region flags for phases 1 to 3.
////////////////////////////////////////

`timescale 1ns/10ps

module cpu_addr_decode (
    input  logic                  sys_clock_i,
    input  logic                  sys_reset_ni,
    input  pet_bus_pkg::phase_t   phase_i,
    input  pet_bus_pkg::cpu_req_t cpu_req_i,
    output pet_bus_pkg::cpu_req_t cpu_req_o,
    output pet_bus_pkg::decode_t  decode_o
);

    pet_bus_pkg::decode_t  decode_d;
    pet_bus_pkg::decode_t  decode_q;
    pet_bus_pkg::cpu_req_t cpu_req_q;
    logic                  latch;

    assign latch = (phase_i == '0);     // Edge that ends phase 0

    always_comb begin
        logic [7:0] page;
        logic [3:0] io_nibble;

        page      = cpu_req_i.addr[pet_bus_pkg::ADDR_WIDTH-1 -: 8];
        io_nibble = cpu_req_i.addr[7:4];

        decode_d.io_en   = (page == pet_bus_pkg::IO_PAGE);
        decode_d.ram_en  = !decode_d.io_en;
        decode_d.is_vram = (page[7:4] == pet_bus_pkg::VRAM_BASE);

        // Everything from $9000 up is ROM, apart from the I/O page
        decode_d.is_readonly = !decode_d.io_en
                            && (cpu_req_i.addr >= pet_bus_pkg::READONLY_BASE);

        decode_d.pia1_en = decode_d.io_en && (io_nibble == pet_bus_pkg::PIA1_NIBBLE);
        decode_d.pia2_en = decode_d.io_en && (io_nibble == pet_bus_pkg::PIA2_NIBBLE);
        decode_d.via_en  = decode_d.io_en && (io_nibble == pet_bus_pkg::VIA_NIBBLE);
    end

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            decode_q <= '0;
        end else if (latch) begin
            decode_q <= decode_d;
        end
    end

    // Address and direction ride along with the flags
    always_ff @(posedge sys_clock_i) begin
        if (latch) begin
            cpu_req_q <= cpu_req_i;
        end
    end

    assign cpu_req_o = cpu_req_q;
    assign decode_o  = decode_q;

    // At most one I/O chip may be selected
    assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        $onehot0({decode_q.pia1_en, decode_q.pia2_en, decode_q.via_en}))
        else $error("More than one I/O chip select decoded");

endmodule

// File: rtl/host_ram_bridge.sv
////////////////////////////////////////
// Host port with a pipelined Wishbone handshake.
// Queues one RAM access and runs it in the next
// full host slot, then acknowledges it.
////////////////////////////////////////

`timescale 1ns/10ps

module host_ram_bridge (
    input  logic                                sys_clock_i,
    input  logic                                sys_reset_ni,
    input  pet_bus_pkg::phase_t                 phase_i,
    input  logic                                host_cyc_i,
    input  logic                                host_stb_i,
    input  pet_bus_pkg::host_req_t              host_req_i,
    output logic                                host_stall_o,
    output logic                                host_ack_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  host_data_o,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  ram_data_i,
    output pet_bus_pkg::ram_ctl_t               ram_ctl_o
);

    logic                               pending_q;  // Request held, doubles as stall
    logic                               run_q;      // Request owns the current host slot
    pet_bus_pkg::host_req_t             req_q;
    logic [pet_bus_pkg::DATA_WIDTH-1:0] rdata_q;
    logic                               accept;
    logic                               ack;
    logic                               in_slot;

    assign accept  = host_cyc_i && host_stb_i && !pending_q;
    assign ack     = run_q && (phase_i == pet_bus_pkg::LAST_PHASE);
    assign in_slot = run_q && (phase_i >= pet_bus_pkg::HOST_SLOT_START);

    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            pending_q <= 1'b0;
            run_q     <= 1'b0;
        end else begin
            if (accept) begin
                pending_q <= 1'b1;
            end else if (ack) begin
                pending_q <= 1'b0;
            end

            // Claim the slot on the edge into phase 4, even if accepted on that edge
            if (phase_i == pet_bus_pkg::CPU_LAST_PHASE) begin
                run_q <= pending_q || accept;
            end else if (ack) begin
                run_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            req_q <= host_req_i;
        end
        if (ack && !req_q.we) begin
            rdata_q <= ram_data_i;      // Sampled at the end of phase 7
        end
    end

    assign host_stall_o = pending_q;
    assign host_ack_o   = ack;

    // Read data shows up with ack and is then held in rdata_q
    assign host_data_o = (ack && !req_q.we) ? ram_data_i : rdata_q;

    always_comb begin
        ram_ctl_o = '0;
        if (in_slot) begin
            ram_ctl_o.addr = req_q.addr;
            ram_ctl_o.oe   = !req_q.we && (phase_i > pet_bus_pkg::HOST_SLOT_START);
            ram_ctl_o.we   = req_q.we && (phase_i == pet_bus_pkg::HOST_WE_PHASE);
            ram_ctl_o.dout = req_q.data;
            ram_ctl_o.doe  = req_q.we;     // Whole slot, covers the WE pulse
        end
    end

    // Host must stay off the RAM pins while the CPU owns the bus
    assert property (@(posedge sys_clock_i) disable iff (!sys_reset_ni)
        (phase_i <= pet_bus_pkg::CPU_LAST_PHASE) |-> (ram_ctl_o == '0))
        else $error("Host RAM control active in the CPU slot");

endmodule

// File: rtl/pet_bus_pkg.sv
////////////////////////////////////////
// Shared frame timing, address map and bus structs
// for the PET bus-sharing core. Modules reference
// these by scoped names.
////////////////////////////////////////

package pet_bus_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 8;

    // Frame layout, CPU owns the first half
    localparam int FRAME_PHASES    = 8;
    localparam int PHASE_WIDTH     = 3;
    localparam int HOST_SLOT_START = 4;

    typedef logic [PHASE_WIDTH-1:0] phase_t;

    localparam phase_t LAST_PHASE     = phase_t'(FRAME_PHASES - 1);
    localparam phase_t CPU_LAST_PHASE = phase_t'(HOST_SLOT_START - 1);
    localparam phase_t HOST_WE_PHASE  = phase_t'(6);    // Middle of the host slot

    // Address map
    localparam logic [3:0]            VRAM_BASE     = 4'h8;     // $8000-$8FFF
    localparam logic [7:0]            IO_PAGE       = 8'hE8;    // $E800-$E8FF
    localparam logic [ADDR_WIDTH-1:0] READONLY_BASE = 16'h9000;

    // Bits 7:4 inside the I/O page
    localparam logic [3:0] PIA1_NIBBLE = 4'h1;
    localparam logic [3:0] PIA2_NIBBLE = 4'h2;
    localparam logic [3:0] VIA_NIBBLE  = 4'h4;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
    } cpu_req_t;

    typedef struct packed {
        logic ram_en;
        logic is_vram;
        logic is_readonly;
        logic io_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
    } decode_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;   // Write data
        logic                  we;
    } host_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  oe;
        logic                  we;
        logic [DATA_WIDTH-1:0] dout;
        logic                  doe;    // Drive dout onto the data bus
    } ram_ctl_t;

endpackage

// File: rtl/pet_bus_top.sv
////////////////////////////////////////
// Top of the PET bus-sharing core. Wires the
// timebase, CPU decode, host bridge and the
// RAM pin driver together.
////////////////////////////////////////

`timescale 1ns/10ps

module pet_bus_top (
    input  logic                                sys_clock_i,
    input  logic                                sys_reset_ni,

    // CPU
    input  logic [pet_bus_pkg::ADDR_WIDTH-1:0]  cpu_addr_i,
    input  logic                                cpu_we_i,
    input  logic [pet_bus_pkg::DATA_WIDTH-1:0]  cpu_data_i,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  cpu_data_o,
    output logic                                cpu_data_oe_o,
    output logic                                cpu_be_o,
    output logic                                cpu_clock_o,

    // RAM and I/O pins
    output logic [pet_bus_pkg::ADDR_WIDTH-1:0]  ram_addr_o,
    output logic                                ram_oe_o,
    output logic                                ram_we_o,
    output logic                                io_oe_o,
    output logic                                pia1_cs_o,
    output logic                                pia2_cs_o,
    output logic                                via_cs_o,

    // Host port
    input  logic                                host_cyc_i,
    input  logic                                host_stb_i,
    input  pet_bus_pkg::host_req_t              host_req_i,
    output logic                                host_stall_o,
    output logic                                host_ack_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  host_data_o,

    // Video config
    input  logic [1:0]                          vram_mask_i,
    input  logic                                col_80_mode_i
);

    pet_bus_pkg::phase_t   phase;
    pet_bus_pkg::cpu_req_t cpu_req;
    pet_bus_pkg::cpu_req_t cpu_req_q;   // Held through phases 1 to 3
    pet_bus_pkg::decode_t  decode;
    pet_bus_pkg::ram_ctl_t host_ctl;

    assign cpu_req = '{addr: cpu_addr_i, we: cpu_we_i};

    slot_timer u_slot_timer (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .phase_o     (phase),
        .cpu_be_o    (cpu_be_o),
        .cpu_clock_o (cpu_clock_o)
    );

    cpu_addr_decode u_cpu_addr_decode (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .phase_i     (phase),
        .cpu_req_i   (cpu_req),
        .cpu_req_o   (cpu_req_q),
        .decode_o    (decode)
    );

    host_ram_bridge u_host_ram_bridge (
        .sys_clock_i (sys_clock_i),
        .sys_reset_ni(sys_reset_ni),
        .phase_i     (phase),
        .host_cyc_i  (host_cyc_i),
        .host_stb_i  (host_stb_i),
        .host_req_i  (host_req_i),
        .host_stall_o(host_stall_o),
        .host_ack_o  (host_ack_o),
        .host_data_o (host_data_o),
        .ram_data_i  (cpu_data_i),      // RAM shares the CPU data bus
        .ram_ctl_o   (host_ctl)
    );

    ram_bus_driver u_ram_bus_driver (
        .phase_i      (phase),
        .cpu_be_i     (cpu_be_o),
        .cpu_clock_i  (cpu_clock_o),
        .cpu_req_i    (cpu_req_q),
        .decode_i     (decode),
        .host_ctl_i   (host_ctl),
        .vram_mask_i  (vram_mask_i),
        .col_80_mode_i(col_80_mode_i),
        .ram_addr_o   (ram_addr_o),
        .ram_oe_o     (ram_oe_o),
        .ram_we_o     (ram_we_o),
        .cpu_data_o   (cpu_data_o),
        .cpu_data_oe_o(cpu_data_oe_o),
        .io_oe_o      (io_oe_o),
        .pia1_cs_o    (pia1_cs_o),
        .pia2_cs_o    (pia2_cs_o),
        .via_cs_o     (via_cs_o)
    );

endmodule

// File: rtl/ram_bus_driver.sv
////////////////////////////////////////
// Drives the RAM and I/O pins. The CPU decode
// owns them in phases 1 to 3, the host bridge
// in the host slot.
////////////////////////////////////////

`timescale 1ns/10ps

module ram_bus_driver (
    input  pet_bus_pkg::phase_t                 phase_i,
    input  logic                                cpu_be_i,
    input  logic                                cpu_clock_i,
    input  pet_bus_pkg::cpu_req_t               cpu_req_i,
    input  pet_bus_pkg::decode_t                decode_i,
    input  pet_bus_pkg::ram_ctl_t               host_ctl_i,
    input  logic [1:0]                          vram_mask_i,
    input  logic                                col_80_mode_i,
    output logic [pet_bus_pkg::ADDR_WIDTH-1:0]  ram_addr_o,
    output logic                                ram_oe_o,
    output logic                                ram_we_o,
    output logic [pet_bus_pkg::DATA_WIDTH-1:0]  cpu_data_o,
    output logic                                cpu_data_oe_o,
    output logic                                io_oe_o,
    output logic                                pia1_cs_o,
    output logic                                pia2_cs_o,
    output logic                                via_cs_o
);

    logic                               cpu_valid;  // Decode holds the current access
    logic                               cpu_wr_strobe;
    logic                               a10_keep;
    logic                               a11_keep;
    logic [pet_bus_pkg::ADDR_WIDTH-1:0] cpu_addr;

    assign cpu_valid     = cpu_be_i && (phase_i != '0);
    assign cpu_wr_strobe = cpu_valid && cpu_clock_i
                        && (phase_i == pet_bus_pkg::CPU_LAST_PHASE);

    // Video RAM wrap, 80 column mode always keeps A10
    assign a10_keep = !decode_i.is_vram || vram_mask_i[0] || col_80_mode_i;
    assign a11_keep = !decode_i.is_vram || vram_mask_i[1];

    always_comb begin
        cpu_addr     = cpu_req_i.addr;
        cpu_addr[10] = cpu_req_i.addr[10] && a10_keep;
        cpu_addr[11] = cpu_req_i.addr[11] && a11_keep;
    end

    assign ram_addr_o = cpu_be_i ? cpu_addr : host_ctl_i.addr;

    assign ram_oe_o = (cpu_valid && !cpu_req_i.we && decode_i.ram_en) || host_ctl_i.oe;

    // ROM writes are dropped
    assign ram_we_o = (cpu_wr_strobe && cpu_req_i.we && decode_i.ram_en
                       && !decode_i.is_readonly)
                   || host_ctl_i.we;

    assign cpu_data_o    = host_ctl_i.dout;
    assign cpu_data_oe_o = host_ctl_i.doe;

    assign io_oe_o   = cpu_valid && decode_i.io_en;
    assign pia1_cs_o = cpu_valid && decode_i.pia1_en;
    assign pia2_cs_o = cpu_valid && decode_i.pia2_en;
    assign via_cs_o  = cpu_valid && decode_i.via_en;

    // Bus contention between I/O chips and RAM, fed by both the decode and host side
    always_comb begin
        assert final (!io_oe_o || (!ram_oe_o && !ram_we_o))
            else $error("I/O and RAM strobes active together");
        assert final (!io_oe_o || cpu_be_i)
            else $error("I/O active outside the CPU slot");
    end

endmodule

// File: rtl/slot_timer.sv
////////////////////////////////////////
// Frame timebase. Counts the eight phases
// of the bus frame and derives the CPU bus
// enable and CPU clock from them.
////////////////////////////////////////

`timescale 1ns/10ps

module slot_timer (
    input  logic                sys_clock_i,
    input  logic                sys_reset_ni,
    output pet_bus_pkg::phase_t phase_o,
    output logic                cpu_be_o,
    output logic                cpu_clock_o
);

    pet_bus_pkg::phase_t phase_q;

    // Phase 0 is held through reset and is the first phase after release
    always_ff @(posedge sys_clock_i or negedge sys_reset_ni) begin
        if (!sys_reset_ni) begin
            phase_q <= '0;
        end else if (phase_q == pet_bus_pkg::LAST_PHASE) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    assign phase_o = phase_q;

    // CPU owns the bus until the host slot starts
    assign cpu_be_o = (phase_q < pet_bus_pkg::HOST_SLOT_START);

    // CPU clock high for the second half of the CPU slot
    assign cpu_clock_o = cpu_be_o && (phase_q >= (pet_bus_pkg::HOST_SLOT_START / 2));

endmodule

// File: sim.f
+incdir+dv
rtl/pet_bus_pkg.sv
rtl/slot_timer.sv
rtl/cpu_addr_decode.sv
rtl/host_ram_bridge.sv
rtl/ram_bus_driver.sv
rtl/pet_bus_top.sv
dv/tb_pet_bus.sv
